// File: core_defs.svh
/* Core-wide constants for the RV32I core: reset vector, register count and
   the major opcode values. Include wherever one of these macros is needed. */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000
// Architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// Major opcodes, inst[6:0]
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_LUI    7'b0110111
`define CORE_OPC_BRANCH 7'b1100011
`define CORE_OPC_JAL    7'b1101111

`endif

// File: core_pkg.sv
/* Shared types of the RV32I core: word and register index vectors, the
   ALU operation code passed from decode to execute, and the fetch FSM states.
   Import with a wildcard in the module header. */

`include "core_defs.svh"

package core_pkg;

  // ------------------------------------------------
  // Vector types
  // ------------------------------------------------

  // Data, address and instruction word
  typedef logic [31:0] word_t;

  // Register file index, sized from the register count
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;

  // ------------------------------------------------
  // Enums
  // ------------------------------------------------

  // Operation selected by decode
  // PASS_B forwards operand b, used for lui
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, PASS_B, BEQ, BNE, JAL, NOP
  } alu_op_t;

  // Fetch FSM, one request per retired instruction
  typedef enum logic [1:0] {
    IDLE, REQ, WAIT_RETIRE
  } fetch_state_t;

endpackage

// File: inst_fetch.sv
/* Instruction fetch: Wishbone classic read master with the pc register.
   Issues one read, captures the word on ack, pulses inst_valid, then waits
   for the retire pulse and its next_pc before fetching again. */

`timescale 1ns/1ps

`include "core_defs.svh"

module inst_fetch import core_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  // Wishbone read bus
  input  logic  wb_ack,
  input  word_t wb_rdata,
  output logic  wb_cyc,
  output logic  wb_stb,
  output word_t wb_adr,
  // From result stage
  input  logic  retire,
  input  word_t next_pc,
  // To decode
  output word_t inst,
  output word_t inst_pc,
  output logic  inst_valid
);

  fetch_state_t state;
  word_t        pc;

  // ------------------------------------------------
  // Fetch FSM and pc
  // ------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      pc         <= `CORE_RESET_PC;
      inst_valid <= 1'b0;
    end else begin
      // Single-cycle pulse by default
      inst_valid <= 1'b0;
      case (state)
        IDLE: state <= REQ;
        REQ: begin
          // Hold the request until the slave acks
          if (wb_ack) begin
            state      <= WAIT_RETIRE;
            inst_valid <= 1'b1;
          end
        end
        WAIT_RETIRE: begin
          if (retire) begin
            state <= REQ;
            pc    <= next_pc;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Instruction register
  // ------------------------------------------------

  // Captured on the ack edge, valid with inst_valid
  always_ff @(posedge clk) begin
    if (state == REQ && wb_ack) begin
      inst    <= wb_rdata;
      inst_pc <= pc;
    end
  end

  // cyc and stb rise and fall together, adr is the held pc
  assign wb_cyc = (state == REQ);
  assign wb_stb = (state == REQ);
  assign wb_adr = pc;

endmodule

// File: inst_decode.sv
/* Combinational decode of one RV32I instruction into an ALU operation,
   destination, immediate and operands. Register reads go out as rs1/rs2
   and the data comes back from the register file in the same cycle. */

`timescale 1ns/1ps

`include "core_defs.svh"

module inst_decode import core_pkg::*; (
  input  word_t     inst,
  input  word_t     inst_pc,
  input  logic      inst_valid,
  // Register file read ports
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  // To execute
  output alu_op_t   op,
  output reg_addr_t rd,
  output word_t     opnd_a,
  output word_t     opnd_b,
  output word_t     imm,
  output word_t     pc,
  output logic      dec_valid
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;
  logic       use_rs2;

  // ------------------------------------------------
  // Fields and immediates
  // ------------------------------------------------

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // All immediates sign-extend from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ------------------------------------------------
  // Operation select
  // ------------------------------------------------

  always_comb begin
    op      = NOP;
    imm     = imm_i;
    use_rs2 = 1'b0;
    case (opcode)
      `CORE_OPC_OP_IMM: begin
        // sltiu and shifts fall through as NOP
        case (funct3)
          3'b000:  op = ADD;
          3'b010:  op = SLT;
          3'b100:  op = XOR;
          3'b110:  op = OR;
          3'b111:  op = AND;
          default: op = NOP;
        endcase
      end
      `CORE_OPC_OP: begin
        use_rs2 = 1'b1;
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = SUB;
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = ADD;
            3'b010:  op = SLT;
            3'b100:  op = XOR;
            3'b110:  op = OR;
            3'b111:  op = AND;
            default: op = NOP;
          endcase
        end
      end
      `CORE_OPC_LUI: begin
        op  = PASS_B;
        imm = imm_u;
      end
      `CORE_OPC_BRANCH: begin
        // Compare rs1 with rs2, target from the B immediate
        use_rs2 = 1'b1;
        imm     = imm_b;
        if (funct3 == 3'b000) op = BEQ;
        else if (funct3 == 3'b001) op = BNE;
      end
      `CORE_OPC_JAL: begin
        op  = JAL;
        imm = imm_j;
      end
      default: op = NOP;
    endcase
  end

  // No destination for branches and unknown encodings
  assign rd = (op == NOP || op == BEQ || op == BNE) ? '0 : inst[11:7];

  assign rs1       = inst[19:15];
  assign rs2       = inst[24:20];
  assign opnd_a    = rs1_data;
  assign opnd_b    = use_rs2 ? rs2_data : imm;
  assign pc        = inst_pc;
  assign dec_valid = inst_valid;

endmodule

// File: alu_execute.sv
/* Execute stage: ALU result, branch decision and next pc, registered when
   decode presents a valid instruction. ex_valid is a one-cycle pulse that
   follows dec_valid by one clock. */

`timescale 1ns/1ps

module alu_execute import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  alu_op_t   op,
  input  reg_addr_t rd,
  input  word_t     opnd_a,
  input  word_t     opnd_b,
  input  word_t     imm,
  input  word_t     pc,
  input  logic      dec_valid,
  output logic      ex_valid,
  output word_t     ex_pc,
  output word_t     ex_result,
  output word_t     ex_next_pc,
  output reg_addr_t ex_rd,
  output logic      ex_wen
);

  word_t pc_plus4;
  word_t alu_result;
  word_t next_pc_d;
  logic  taken;
  logic  writes;

  // ------------------------------------------------
  // ALU and branch unit
  // ------------------------------------------------

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    alu_result = '0;
    writes     = 1'b1;
    case (op)
      ADD:    alu_result = opnd_a + opnd_b;
      SUB:    alu_result = opnd_a - opnd_b;
      AND:    alu_result = opnd_a & opnd_b;
      OR:     alu_result = opnd_a | opnd_b;
      XOR:    alu_result = opnd_a ^ opnd_b;
      // Signed compare
      SLT:    alu_result[0] = ($signed(opnd_a) < $signed(opnd_b));
      PASS_B: alu_result = opnd_b;
      // Link address
      JAL:    alu_result = pc_plus4;
      default: writes = 1'b0;
    endcase
  end

  // jal always jumps, branches on compare
  assign taken = (op == JAL) ||
                 (op == BEQ && opnd_a == opnd_b) ||
                 (op == BNE && opnd_a != opnd_b);
  assign next_pc_d = taken ? (pc + imm) : pc_plus4;

  // ------------------------------------------------
  // Execute register
  // ------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) ex_valid <= 1'b0;
    else         ex_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_pc      <= pc;
      ex_rd      <= rd;
      ex_result  <= alu_result;
      ex_next_pc <= next_pc_d;
      // x0 is never a write target
      ex_wen     <= writes && (rd != '0);
    end
  end

endmodule

// File: reg_writeback.sv
/* Result stage: owns the register file, writes the executed result, drives
   the registered trace port and returns retire plus next_pc to fetch.
   Read ports are combinational and x0 always reads as zero. */

`timescale 1ns/1ps

module reg_writeback import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  // From execute
  input  logic      ex_valid,
  input  logic      ex_wen,
  input  word_t     ex_pc,
  input  word_t     ex_result,
  input  word_t     ex_next_pc,
  input  reg_addr_t ex_rd,
  // Decode read ports
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  // Back to fetch
  output logic      retire,
  output word_t     next_pc,
  // Trace port
  output logic      trace_val,
  output logic      trace_wen,
  output word_t     trace_pc,
  output word_t     trace_wdata,
  output reg_addr_t trace_waddr
);

  localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

  word_t regs [NUM_REGS];
  logic  wr_en;

  // ------------------------------------------------
  // Register file
  // ------------------------------------------------

  // Execute already clears wen for x0
  assign wr_en = ex_valid && ex_wen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[ex_rd] <= ex_result;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // ------------------------------------------------
  // Trace and retire
  // ------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trace_val <= 1'b0;
      trace_wen <= 1'b0;
      retire    <= 1'b0;
    end else begin
      trace_val <= ex_valid;
      trace_wen <= wr_en;
      retire    <= ex_valid;
    end
  end

  // Address and data read as zero when nothing is written
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      trace_pc    <= ex_pc;
      trace_waddr <= wr_en ? ex_rd : '0;
      trace_wdata <= wr_en ? ex_result : '0;
      next_pc     <= ex_next_pc;
    end
  end

endmodule

// File: core_top.sv
/* Top of the RV32I core: fetch, decode, execute and result stages with
   one instruction in flight. Exposes the Wishbone read bus and the
   retirement trace port. */

`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  // Wishbone classic read bus
  output logic      wb_cyc,
  output logic      wb_stb,
  output word_t     wb_adr,
  input  word_t     wb_rdata,
  input  logic      wb_ack,
  // Retirement trace
  output logic      trace_val,
  output word_t     trace_pc,
  output reg_addr_t trace_waddr,
  output word_t     trace_wdata,
  output logic      trace_wen
);

  // ------------------------------------------------
  // Stage to stage wires
  // ------------------------------------------------

  // Fetch to decode
  word_t     inst;
  word_t     inst_pc;
  logic      inst_valid;
  // Decode and register file
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  // Decode to execute
  alu_op_t   op;
  reg_addr_t rd;
  word_t     opnd_a;
  word_t     opnd_b;
  word_t     imm;
  word_t     dec_pc;
  logic      dec_valid;
  // Execute to result
  logic      ex_valid;
  logic      ex_wen;
  word_t     ex_pc;
  word_t     ex_result;
  word_t     ex_next_pc;
  reg_addr_t ex_rd;
  // Result to fetch
  logic      retire;
  word_t     next_pc;

  // ------------------------------------------------
  // Stages
  // ------------------------------------------------

  inst_fetch u_fetch (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_ack     (wb_ack),
    .wb_rdata   (wb_rdata),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .retire     (retire),
    .next_pc    (next_pc),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid)
  );

  inst_decode u_decode (
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .rs1        (rs1),
    .rs2        (rs2),
    .op         (op),
    .rd         (rd),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .imm        (imm),
    .pc         (dec_pc),
    .dec_valid  (dec_valid)
  );

  alu_execute u_execute (
    .clk        (clk),
    .arst_n     (arst_n),
    .op         (op),
    .rd         (rd),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .imm        (imm),
    .pc         (dec_pc),
    .dec_valid  (dec_valid),
    .ex_valid   (ex_valid),
    .ex_pc      (ex_pc),
    .ex_result  (ex_result),
    .ex_next_pc (ex_next_pc),
    .ex_rd      (ex_rd),
    .ex_wen     (ex_wen)
  );

  reg_writeback u_writeback (
    .clk         (clk),
    .arst_n      (arst_n),
    .ex_valid    (ex_valid),
    .ex_wen      (ex_wen),
    .ex_pc       (ex_pc),
    .ex_result   (ex_result),
    .ex_next_pc  (ex_next_pc),
    .ex_rd       (ex_rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .retire      (retire),
    .next_pc     (next_pc),
    .trace_val   (trace_val),
    .trace_wen   (trace_wen),
    .trace_pc    (trace_pc),
    .trace_wdata (trace_wdata),
    .trace_waddr (trace_waddr)
  );

endmodule

// File: core_asserts.sv
/* Concurrent checks on the core's Wishbone read master and its trace port.
   Attached to core_top by the bind at the bottom of this file. */

`timescale 1ns/1ps

module core_asserts import core_pkg::*; (
  input logic      clk,
  input logic      arst_n,
  input logic      wb_cyc,
  input logic      wb_stb,
  input logic      wb_ack,
  input word_t     wb_adr,
  input logic      trace_val,
  input logic      trace_wen,
  input reg_addr_t trace_waddr
);

  // Count of failed assertions
  int n_fail = 0;

  // ------------------------------------------------
  // Bus protocol
  // ------------------------------------------------

  // Request held with the same address until ack
  hold_req: assert property (@(posedge clk) disable iff (!arst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
  else begin
    $error("stb dropped or adr changed before ack");
    n_fail = n_fail + 1;
  end

  // Master releases the bus in the cycle after ack
  ack_release: assert property (@(posedge clk) disable iff (!arst_n)
    wb_stb && wb_ack |=> !wb_cyc && !wb_stb)
  else begin
    $error("cyc or stb still high after ack");
    n_fail = n_fail + 1;
  end

  // ------------------------------------------------
  // Trace rules
  // ------------------------------------------------

  // x0 never shows as written
  wen_addr: assert property (@(posedge clk) disable iff (!arst_n)
    trace_wen |-> trace_waddr != '0)
  else begin
    $error("trace_wen with waddr 0");
    n_fail = n_fail + 1;
  end

  val_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    trace_val |=> !trace_val)
  else begin
    $error("trace_val high for more than one cycle");
    n_fail = n_fail + 1;
  end

endmodule

bind core_top core_asserts asrt_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .wb_cyc      (wb_cyc),
  .wb_stb      (wb_stb),
  .wb_ack      (wb_ack),
  .wb_adr      (wb_adr),
  .trace_val   (trace_val),
  .trace_wen   (trace_wen),
  .trace_waddr (trace_waddr)
);

// File: tb_wb_mem.sv
/* Wishbone classic read slave for the core testbench. The testbench top
   loads the word array; each request is acked after 0 to MAX_WAIT random
   wait cycles, with ack and rdata driven on the falling edge. */

`timescale 1ns/1ps

module tb_wb_mem #(
  parameter int MAX_WAIT = 3
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic [31:0] adr,
  output logic [31:0] rdata,
  output logic        ack
);

  // 64 words, byte addresses 0x00 to 0xfc
  logic [31:0] mem [64];
  logic        busy;
  int          wait_left;

  always @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack       <= 1'b0;
      rdata     <= '0;
      busy      = 1'b0;
      wait_left = 0;
    end else if (ack) begin
      // Ack lasts one cycle, master drops stb after it
      ack  <= 1'b0;
      busy = 1'b0;
    end else if (cyc && stb) begin
      // New request, draw its wait states once
      if (!busy) begin
        busy      = 1'b1;
        wait_left = $urandom % (MAX_WAIT + 1);
      end
      if (wait_left == 0) begin
        ack   <= 1'b1;
        // Outside the array the fill follows the full address
        rdata <= (adr[31:8] == '0) ? mem[adr[7:2]] : (32'hbad0_0000 ^ adr);
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

endmodule

// File: tb_trace_checker.sv
/* Trace checker for the core testbench. On every trace_val it compares the
   retired pc, waddr, wdata and wen with the expected entry presented by the
   testbench top, prints one line per entry and keeps the counts. */

`timescale 1ns/1ps

module tb_trace_checker import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  // Trace port of the DUT
  input  logic      trace_val,
  input  logic      trace_wen,
  input  word_t     trace_pc,
  input  word_t     trace_wdata,
  input  reg_addr_t trace_waddr,
  // Expected entry from the table
  input  logic      exp_armed,
  input  int        exp_idx,
  input  word_t     exp_pc,
  input  word_t     exp_wdata,
  input  reg_addr_t exp_waddr,
  input  logic      exp_wen,
  output int        n_seen,
  output int        n_err
);

  int entry_errs;

  task automatic compare_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: test %0d %s is %h, expected %h",
               $time, exp_idx, name, got, exp);
      entry_errs = entry_errs + 1;
    end
  endtask

  // Sampled on the edge that ends the trace_val cycle
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      n_seen <= 0;
      n_err  <= 0;
    end else if (trace_val) begin
      entry_errs = 0;
      if (!exp_armed) begin
        $display("Retirement at pc %h with no expected entry left", trace_pc);
        entry_errs = 1;
      end else begin
        compare_field("pc", trace_pc, exp_pc);
        compare_field("waddr", word_t'(trace_waddr), word_t'(exp_waddr));
        compare_field("wdata", trace_wdata, exp_wdata);
        compare_field("wen", word_t'(trace_wen), word_t'(exp_wen));
        if (entry_errs == 0) begin
          $display("ok     test %0d  pc %h  x%0d <= %h  wen %0d",
                   exp_idx, trace_pc, trace_waddr, trace_wdata, trace_wen);
        end
      end
      n_seen <= n_seen + 1;
      n_err  <= n_err + entry_errs;
    end
  end

endmodule

// File: tb_core.sv
/* Testbench top for the RV32I core. Loads a short program into the memory
   model, then presents the expected trace table one retirement at a time
   to the checker and prints the counts and the verdict at the end. */

`timescale 1ns/1ps

module tb_core;

  localparam logic [31:0] SEED           = 32'hf66a;
  localparam int          MAX_WAIT       = 3;
  localparam int          TIMEOUT_CYCLES = 40;
  localparam int          MAX_TESTS      = 40;
  localparam int          MEM_WORDS      = 64;

  // Major opcodes
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_ack;
  logic [31:0] wb_adr;
  logic [31:0] wb_rdata;
  logic        trace_val;
  logic        trace_wen;
  logic [31:0] trace_pc;
  logic [31:0] trace_wdata;
  logic [4:0]  trace_waddr;

  // Entry presented to the checker
  logic        exp_armed;
  int          exp_idx;
  logic [31:0] exp_pc;
  logic [31:0] exp_wdata;
  logic [4:0]  exp_waddr;
  logic        exp_wen;
  int          n_seen;
  int          n_err;

  // Expected trace, program order along the taken paths
  logic [31:0] tbl_pc    [MAX_TESTS];
  logic [4:0]  tbl_waddr [MAX_TESTS];
  logic [31:0] tbl_wdata [MAX_TESTS];
  logic        tbl_wen   [MAX_TESTS];
  int          n_tests = 0;

  core_top dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_adr      (wb_adr),
    .wb_rdata    (wb_rdata),
    .wb_ack      (wb_ack),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  tb_wb_mem #(.MAX_WAIT(MAX_WAIT)) mem_i (
    .clk    (clk),
    .arst_n (arst_n),
    .cyc    (wb_cyc),
    .stb    (wb_stb),
    .adr    (wb_adr),
    .rdata  (wb_rdata),
    .ack    (wb_ack)
  );

  tb_trace_checker chk_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .trace_val   (trace_val),
    .trace_wen   (trace_wen),
    .trace_pc    (trace_pc),
    .trace_wdata (trace_wdata),
    .trace_waddr (trace_waddr),
    .exp_armed   (exp_armed),
    .exp_idx     (exp_idx),
    .exp_pc      (exp_pc),
    .exp_wdata   (exp_wdata),
    .exp_waddr   (exp_waddr),
    .exp_wen     (exp_wen),
    .n_seen      (n_seen),
    .n_err       (n_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------
  // Instruction encoders, RV32I formats
  // ------------------------------------------------

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] enc_u(int imm, int rd);
    return {imm[19:0], rd[4:0], OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  // ------------------------------------------------
  // Program and expected trace
  // ------------------------------------------------

  task automatic place(input int addr, input logic [31:0] word);
    mem_i.mem[addr[7:2]] = word;
  endtask

  // rd 0 means nothing is written, so waddr and wdata are expected as 0
  task automatic expect_retire(input int addr, input logic [31:0] word, input int rd,
                               input logic [31:0] data);
    place(addr, word);
    tbl_pc[n_tests]    = addr;
    tbl_waddr[n_tests] = rd[4:0];
    tbl_wdata[n_tests] = (rd != 0) ? data : '0;
    tbl_wen[n_tests]   = (rd != 0);
    n_tests = n_tests + 1;
  endtask

  task automatic load_program();
    logic [31:0] skip_word;
    skip_word = enc_i(-1, 0, 0, 31, OPC_IMM);
    // Fill shows up as an unknown encoding if ever fetched
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_i.mem[i] = 32'hbad0_0000 ^ (i << 2);
    end
    // Immediate ops, negative immediates sign-extended
    expect_retire('h00, enc_i(5, 0, 0, 1, OPC_IMM), 1, 32'h0000_0005);
    expect_retire('h04, enc_i(-3, 0, 0, 2, OPC_IMM), 2, 32'hffff_fffd);
    expect_retire('h08, enc_i('h0f0, 2, 7, 3, OPC_IMM), 3, 32'h0000_00f0);
    expect_retire('h0c, enc_i(-16, 1, 6, 4, OPC_IMM), 4, 32'hffff_fff5);
    expect_retire('h10, enc_i(-1, 1, 4, 5, OPC_IMM), 5, 32'hffff_fffa);
    expect_retire('h14, enc_i(1, 2, 2, 6, OPC_IMM), 6, 32'h0000_0001);
    expect_retire('h18, enc_i(-1, 1, 2, 7, OPC_IMM), 7, 32'h0000_0000);
    // Register ops on earlier results, then lui
    expect_retire('h1c, enc_r(0, 2, 1, 0, 8), 8, 32'h0000_0002);
    expect_retire('h20, enc_r('h20, 2, 1, 0, 9), 9, 32'h0000_0008);
    expect_retire('h24, enc_r(0, 3, 4, 7, 10), 10, 32'h0000_00f0);
    expect_retire('h28, enc_r(0, 3, 1, 6, 11), 11, 32'h0000_00f5);
    expect_retire('h2c, enc_r(0, 5, 4, 4, 12), 12, 32'h0000_000f);
    expect_retire('h30, enc_r(0, 1, 2, 2, 13), 13, 32'h0000_0001);
    expect_retire('h34, enc_u('h12345, 14), 14, 32'h1234_5000);
    // Write to x0 is dropped, x0 still reads 0
    expect_retire('h38, enc_i(7, 1, 0, 0, OPC_IMM), 0, 32'h0);
    expect_retire('h3c, enc_r(0, 1, 0, 0, 15), 15, 32'h0000_0005);
    // Taken beq, not-taken bne, taken bne, not-taken beq
    expect_retire('h40, enc_b(8, 15, 1, 0), 0, 32'h0);
    place('h44, skip_word);
    expect_retire('h48, enc_b(8, 15, 1, 1), 0, 32'h0);
    expect_retire('h4c, enc_b(12, 2, 1, 1), 0, 32'h0);
    place('h50, skip_word);
    place('h54, skip_word);
    expect_retire('h58, enc_b(8, 2, 1, 0), 0, 32'h0);
    // jal links pc + 4
    expect_retire('h5c, enc_j(12, 17), 17, 32'h0000_0060);
    place('h60, skip_word);
    place('h64, skip_word);
    // All ones and a store, both unknown here
    expect_retire('h68, 32'hffff_ffff, 0, 32'h0);
    expect_retire('h6c, 32'h0011_2023, 0, 32'h0);
    expect_retire('h70, enc_i(4, 17, 0, 18, OPC_IMM), 18, 32'h0000_0064);
    expect_retire('h74, enc_j(8, 0), 0, 32'h0);
    // Backward bne loop, x19 counts up to x8
    expect_retire('h7c, enc_b(-4, 8, 19, 1), 0, 32'h0);
    expect_retire('h78, enc_i(1, 19, 0, 19, OPC_IMM), 19, 32'h0000_0001);
    expect_retire('h7c, enc_b(-4, 8, 19, 1), 0, 32'h0);
    expect_retire('h78, enc_i(1, 19, 0, 19, OPC_IMM), 19, 32'h0000_0002);
    expect_retire('h7c, enc_b(-4, 8, 19, 1), 0, 32'h0);
    expect_retire('h80, enc_r(0, 14, 19, 0, 20), 20, 32'h1234_5002);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    int seen_before;
    int wait_cycles;
    int timeouts;
    timeouts  = 0;
    arst_n    = 1'b0;
    exp_armed = 1'b0;
    exp_idx   = 0;
    exp_pc    = '0;
    exp_wdata = '0;
    exp_waddr = '0;
    exp_wen   = 1'b0;
    void'($urandom(SEED));
    load_program();

    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    // One entry per retirement, each with its own timeout
    for (int k = 0; k < n_tests; k++) begin
      exp_idx     = k;
      exp_pc      = tbl_pc[k];
      exp_waddr   = tbl_waddr[k];
      exp_wdata   = tbl_wdata[k];
      exp_wen     = tbl_wen[k];
      exp_armed   = 1'b1;
      seen_before = n_seen;
      wait_cycles = 0;
      while (n_seen == seen_before && wait_cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        wait_cycles = wait_cycles + 1;
      end
      if (n_seen == seen_before) begin
        $display("test %0d at pc %h: no retirement within timeout", k, tbl_pc[k]);
        timeouts = timeouts + 1;
        break;
      end
    end
    exp_armed = 1'b0;

    $display("tests %0d  retired %0d  mismatches %0d  timeouts %0d  assertion failures %0d",
             n_tests, n_seen, n_err, timeouts, dut_i.asrt_i.n_fail);
    if (n_err == 0 && timeouts == 0 && n_seen == n_tests && dut_i.asrt_i.n_fail == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
core_pkg.sv
inst_fetch.sv
inst_decode.sv
alu_execute.sv
reg_writeback.sv
core_top.sv
core_asserts.sv
tb_wb_mem.sv
tb_trace_checker.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, and look for the pass line.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_core -Mdir obj_dir -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Let the run go on after an assertion error so the testbench prints its verdict
sim_out=$(./obj_dir/Vtb_core +verilator+error+limit+1000)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
